// File: source/debug_scan_pkg.sv
`default_nettype none

package debug_scan_pkg;

    localparam int reg_addr_w = 5;
    localparam int reg_data_w = 32;
    localparam int div_w      = 26;
    localparam int nibble_w   = 4;
    localparam int seg_w      = 8;
    localparam int num_digits = 6;
    localparam int hex_w      = num_digits * seg_w;   // all digits side by side

    typedef logic [reg_addr_w-1 : 0]    reg_addr_t;     // scan register address
    typedef logic [reg_data_w-1 : 0]    reg_data_t;     // scan register data
    typedef logic [nibble_w-1   : 0]    nibble_t;
    typedef logic [seg_w-1      : 0]    seg_t;          // bit 7 is the decimal point
    typedef logic [div_w-1      : 0]    div_t;          // auto scan rate

    // segments a..g on bits 0..6, decimal point left dark
    function automatic seg_t hex_to_seg(input nibble_t nib);
        seg_t seg;
        case (nib)
            4'h0    : seg = 8'h3f;
            4'h1    : seg = 8'h06;
            4'h2    : seg = 8'h5b;
            4'h3    : seg = 8'h4f;
            4'h4    : seg = 8'h66;
            4'h5    : seg = 8'h6d;
            4'h6    : seg = 8'h7d;
            4'h7    : seg = 8'h07;
            4'h8    : seg = 8'h7f;
            4'h9    : seg = 8'h6f;
            4'ha    : seg = 8'h77;
            4'hb    : seg = 8'h7c;  // lower case b
            4'hc    : seg = 8'h39;
            4'hd    : seg = 8'h5e;  // lower case d
            4'he    : seg = 8'h79;
            default : seg = 8'h71;  // f
        endcase
        return seg;
    endfunction

endpackage : debug_scan_pkg

`default_nettype wire

// File: source/capture_if.sv
`timescale 1ns/10ps
`default_nettype none

interface capture_if;

    import debug_scan_pkg::*;

    logic       valid;      // sample present
    reg_addr_t  addr;       // register the data was read from
    reg_data_t  data;       // register value
    logic       upper;      // show bits 31..16 instead of 15..0

    // capture stage writes a whole sample at once
    modport source
    (
        output  valid,
        output  addr,
        output  data,
        output  upper
    );

    modport sink
    (
        input   valid,
        input   addr,
        input   data,
        input   upper
    );

endinterface : capture_if

`default_nettype wire

// File: source/scan_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module scan_addr_gen
#(
    parameter int unsigned              num_regs = 32
)
(
    input   logic                       clk,
    input   logic                       resetn,
    input   logic                       auto_scan,  // 1 = step through registers
    input   debug_scan_pkg::reg_addr_t  sel_addr,   // manual address from switches
    input   debug_scan_pkg::div_t       div,        // step every div+1 cycles
    output  debug_scan_pkg::reg_addr_t  scan_addr,
    output  logic                       scan_valid
);

    import debug_scan_pkg::*;

    localparam reg_addr_t last_addr = reg_addr_t'(num_regs - 1);

    div_t       prescale;       // cycles since the last step
    logic       step;
    reg_addr_t  manual_addr;
    reg_addr_t  next_addr;

    // >= so that a smaller div written mid count still wraps right away
    assign step        = prescale >= div;
    // switches can point past the last register, clamp them
    assign manual_addr = (sel_addr > last_addr) ? last_addr : sel_addr;
    assign next_addr   = (scan_addr == last_addr) ? '0 : scan_addr + 1'b1;

    always_ff @(posedge clk, negedge resetn)
        if (!resetn)
        begin
            prescale   <= '0;
            scan_addr  <= '0;
            scan_valid <= 1'b0;
        end
        else
        begin
            scan_valid <= 1'b1;     // address is meaningful from the first edge on
            if (!auto_scan)
            begin
                prescale  <= '0;    // restart the step period on entry to auto
                scan_addr <= manual_addr;
            end
            else if (step)
            begin
                prescale  <= '0;
                scan_addr <= next_addr;
            end
            else
                prescale <= prescale + 1'b1;
        end

    // the cpu only decodes num_regs registers
    addr_in_range : assert property
    (
        @(posedge clk) disable iff (!resetn)
        scan_addr <= last_addr
    )
    else
        $error("scan_addr %0d out of range for %0d registers", scan_addr, num_regs);

endmodule : scan_addr_gen

`default_nettype wire

// File: source/scan_capture.sv
`timescale 1ns/10ps
`default_nettype none

module scan_capture
(
    input   logic                       clk,
    input   logic                       resetn,
    input   debug_scan_pkg::reg_addr_t  scan_addr,  // address currently on the scan port
    input   logic                       scan_valid,
    input   debug_scan_pkg::reg_data_t  reg_data,   // cpu answer to scan_addr
    input   logic                       upper_half, // half select from the switch
    capture_if.source                   cap
);

    always_ff @(posedge clk, negedge resetn)
        if (!resetn)
            cap.valid <= 1'b0;
        else
            cap.valid <= scan_valid;

    // address and data are taken on the same edge so they stay paired
    always_ff @(posedge clk)
        if (scan_valid)
        begin
            cap.addr  <= scan_addr;
            cap.data  <= reg_data;
            cap.upper <= upper_half;
        end

    // a valid sample must be fully defined
    sample_known : assert property
    (
        @(posedge clk) disable iff (!resetn)
        cap.valid |-> !$isunknown({cap.addr, cap.data, cap.upper})
    )
    else
        $error("capture sample carries X while valid");

endmodule : scan_capture

`default_nettype wire

// File: source/seg_display_encode.sv
`timescale 1ns/10ps
`default_nettype none

module seg_display_encode
#(
    parameter bit                               active_low_segments = 1'b1
)
(
    input   logic                               clk,
    input   logic                               resetn,
    capture_if.sink                             cap,
    output  logic [debug_scan_pkg::hex_w-1 : 0] hex     // digit 5 in the top byte
);

    import debug_scan_pkg::*;

    localparam int half_w = reg_data_w / 2;
    localparam int dp_bit = seg_w - 1;

    // xor mask for common anode digits
    localparam logic [hex_w-1 : 0] pol_mask = {hex_w{active_low_segments}};

    logic [seg_w-1  : 0]    addr_ext;           // address zero extended to two digits
    logic [half_w-1 : 0]    half;               // 16 bits picked for digits 3..0
    nibble_t                nibs [num_digits];
    logic [hex_w-1  : 0]    lit_hex;            // 1 = segment lit

    always_comb
    begin
        addr_ext = seg_w'(cap.addr);
        half     = cap.upper ? cap.data[reg_data_w-1 -: half_w] : cap.data[half_w-1 : 0];

        nibs[5]  = addr_ext[seg_w-1 -: nibble_w];
        nibs[4]  = addr_ext[nibble_w-1 : 0];
        for (int i = 0; i < 4; i++)
            nibs[i] = half[i*nibble_w +: nibble_w];

        for (int i = 0; i < num_digits; i++)
            lit_hex[i*seg_w +: seg_w] = hex_to_seg(nibs[i]);

        // dot after the address marks the upper half
        lit_hex[4*seg_w + dp_bit] = cap.upper;
    end

    always_ff @(posedge clk, negedge resetn)
        if (!resetn)
            hex <= pol_mask;                // every segment dark
        else if (cap.valid)
            hex <= lit_hex ^ pol_mask;      // otherwise hold the last sample

endmodule : seg_display_encode

`default_nettype wire

// File: source/debug_scan_top.sv
`timescale 1ns/10ps
`default_nettype none

module debug_scan_top
#(
    parameter int unsigned                      num_regs            = 32,
    parameter bit                               active_low_segments = 1'b1
)
(
    // clock and reset
    input   logic                               clk,
    input   logic                               resetn,
    // controls
    input   logic                               auto_scan,      // 0 = address from switches
    input   logic                               upper_half,     // show upper 16 bits
    input   debug_scan_pkg::reg_addr_t          sel_addr,
    input   debug_scan_pkg::div_t               div,
    // cpu scan port
    input   debug_scan_pkg::reg_data_t          reg_data,       // answers reg_addr same cycle
    output  debug_scan_pkg::reg_addr_t          reg_addr,
    // seven segment digits
    output  logic [debug_scan_pkg::hex_w-1 : 0] hex
);

    logic       scan_valid;     // address stage has a real address out

    capture_if  cap_if ();      // captured sample to the display

    // address picker, manual or auto
    scan_addr_gen
    #(
        .num_regs   ( num_regs      )
    )
    scan_addr_gen_0
    (
        .clk        ( clk           ),
        .resetn     ( resetn        ),
        .auto_scan  ( auto_scan     ),
        .sel_addr   ( sel_addr      ),
        .div        ( div           ),
        .scan_addr  ( reg_addr      ),  // straight out to the cpu
        .scan_valid ( scan_valid    )
    );

    scan_capture scan_capture_0
    (
        .clk        ( clk           ),
        .resetn     ( resetn        ),
        .scan_addr  ( reg_addr      ),
        .scan_valid ( scan_valid    ),
        .reg_data   ( reg_data      ),
        .upper_half ( upper_half    ),
        .cap        ( cap_if        )
    );

    seg_display_encode
    #(
        .active_low_segments    ( active_low_segments   )
    )
    seg_display_encode_0
    (
        .clk        ( clk           ),
        .resetn     ( resetn        ),
        .cap        ( cap_if        ),
        .hex        ( hex           )
    );

endmodule : debug_scan_top

`default_nettype wire

// File: bench/debug_scan_tb.sv
`timescale 1ns/10ps
`default_nettype none

module debug_scan_tb;

    import debug_scan_pkg::*;

    localparam int num_regs    = 12;
    localparam int clk_period  = 100;
    localparam int reset_len   = 8;
    // tests take roughly 200 cycles, the limit leaves a wide margin
    localparam int max_cycles  = 2000;

    logic           clk;
    logic           resetn;
    logic           auto_scan;
    logic           upper_half;
    reg_addr_t      sel_addr;
    div_t           div;
    reg_data_t      reg_data;
    reg_addr_t      reg_addr;
    logic [47:0]    hex;

    reg_data_t      reg_table [32];     // cpu register file model
    logic [31:0]    lcg_state;
    int             cycle_count = 0;
    int             checks;
    int             errors;

    debug_scan_top
    #(
        .num_regs               ( num_regs      ),
        .active_low_segments    ( 1'b1          )
    )
    dut_i
    (
        .clk        ( clk           ),
        .resetn     ( resetn        ),
        .auto_scan  ( auto_scan     ),
        .upper_half ( upper_half    ),
        .sel_addr   ( sel_addr      ),
        .div        ( div           ),
        .reg_data   ( reg_data      ),
        .reg_addr   ( reg_addr      ),
        .hex        ( hex           )
    );

    // scan port answers in the same cycle
    assign reg_data = reg_table[reg_addr];

    initial
    begin
        clk = 1'b0;
        forever
            #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // standard glyphs, bit 0 = a .. bit 6 = g, dot dark
    function automatic logic [7:0] glyph_of(input logic [3:0] nib);
        logic [7:0] g;
        case (nib)
            4'h0    : g = 8'b0011_1111;
            4'h1    : g = 8'b0000_0110;
            4'h2    : g = 8'b0101_1011;
            4'h3    : g = 8'b0100_1111;
            4'h4    : g = 8'b0110_0110;
            4'h5    : g = 8'b0110_1101;
            4'h6    : g = 8'b0111_1101;
            4'h7    : g = 8'b0000_0111;
            4'h8    : g = 8'b0111_1111;
            4'h9    : g = 8'b0110_1111;
            4'ha    : g = 8'b0111_0111;
            4'hb    : g = 8'b0111_1100;
            4'hc    : g = 8'b0011_1001;
            4'hd    : g = 8'b0101_1110;
            4'he    : g = 8'b0111_1001;
            default : g = 8'b0111_0001;
        endcase
        return g;
    endfunction

    // six digits as the board should show them, common anode
    function automatic logic [47:0] expected_hex(input reg_addr_t addr, input reg_data_t data,
                                                 input logic upper);
        logic [7:0]     addr8;
        logic [15:0]    half;
        logic [47:0]    lit;
        addr8 = {3'b000, addr};
        half  = upper ? data[31:16] : data[15:0];
        lit[47:40] = glyph_of(addr8[7:4]);
        lit[39:32] = glyph_of(addr8[3:0]) | {upper, 7'b000_0000};   // dot marks upper half
        lit[31:24] = glyph_of(half[15:12]);
        lit[23:16] = glyph_of(half[11:8]);
        lit[15:8]  = glyph_of(half[7:4]);
        lit[7:0]   = glyph_of(half[3:0]);
        return ~lit;
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input logic [47:0] expected, input logic [47:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // drive a manual setting at a falling edge and check the display 3 cycles later
    task automatic run_manual(input string test_name, input reg_addr_t addr, input logic upper);
        logic [47:0]    old_hex;
        logic           same_half;
        old_hex    = hex;
        same_half  = (upper == upper_half);
        auto_scan  = 1'b0;
        sel_addr   = addr;
        upper_half = upper;
        repeat (2) @(negedge clk);
        // half select skips the address stage and lands a cycle sooner
        if (same_half)
            check_value(test_name, "hex before latency", old_hex, hex);
        @(negedge clk);
        check_value(test_name, "reg_addr", 48'(addr), 48'(reg_addr));
        check_value(test_name, "hex", expected_hex(addr, reg_table[addr], upper), hex);
    endtask

    task automatic reset_state();
        repeat (reset_len)
        begin
            @(negedge clk);
            check_value("reset_state", "hex", {48{1'b1}}, hex);
            check_value("reset_state", "reg_addr", 48'd0, 48'(reg_addr));
        end
        resetn = 1'b1;
        @(negedge clk);
        check_value("reset_state", "hex after release", {48{1'b1}}, hex);
        check_value("reset_state", "reg_addr after release", 48'd0, 48'(reg_addr));
        repeat (2) @(negedge clk);  // register 0 reaches the digits
        check_value("reset_state", "hex of register 0",
                    expected_hex(5'd0, reg_table[0], 1'b0), hex);
    endtask

    task automatic manual_lower();
        run_manual("manual_lower", 5'd3, 1'b0);
        run_manual("manual_lower", 5'd7, 1'b0);
        run_manual("manual_lower", 5'd11, 1'b0);
        run_manual("manual_lower", 5'd0, 1'b0);
        check_value("manual_lower", "dot of digit 4", 48'd1, 48'(hex[39]));
    endtask

    task automatic manual_upper();
        run_manual("manual_upper", 5'd5, 1'b1);
        run_manual("manual_upper", 5'd10, 1'b1);
        run_manual("manual_upper", 5'd2, 1'b0);
        run_manual("manual_upper", 5'd2, 1'b1);     // half select alone
        check_value("manual_upper", "dot of digit 4", 48'd0, 48'(hex[39]));
    endtask

    // step until reg_addr leaves prev or the wait runs out
    task automatic wait_addr_change(input reg_addr_t prev, input int limit, output logic changed);
        int n;
        changed = 1'b0;
        for (n = 0; n < limit && !changed; n++)
        begin
            @(negedge clk);
            changed = (reg_addr != prev);
        end
    endtask

    task automatic auto_scan_wrap();
        reg_addr_t  prev;
        reg_addr_t  next;
        int         last;
        logic       changed;
        logic       saw_wrap;
        run_manual("auto_scan_wrap", 5'd9, 1'b0);  // start near the wrap
        saw_wrap  = 1'b0;
        prev      = reg_addr;
        div       = 26'd3;
        auto_scan = 1'b1;
        last      = cycle_count;
        for (int s = 0; s < 14; s++)
        begin
            wait_addr_change(prev, 8, changed);
            assert (changed)
            else
            begin
                errors++;
                $display("auto_scan_wrap: reg_addr stuck at %0d in auto mode", prev);
            end
            if (!changed)
                return;
            next = (prev == num_regs - 1) ? 5'd0 : prev + 5'd1;
            check_value("auto_scan_wrap", "step length", 48'd4, 48'(cycle_count - last));
            check_value("auto_scan_wrap", "reg_addr", 48'(next), 48'(reg_addr));
            if (prev == num_regs - 1 && reg_addr == 0)
                saw_wrap = 1'b1;
            prev = reg_addr;
            last = cycle_count;
            repeat (2) @(negedge clk);
            check_value("auto_scan_wrap", "hex", expected_hex(prev, reg_table[prev], 1'b0), hex);
        end
        check_value("auto_scan_wrap", "wrap seen", 48'd1, 48'(saw_wrap));
        auto_scan = 1'b0;
        sel_addr  = 5'd0;
        repeat (4) @(negedge clk);   // let the pipe settle on manual
    endtask

    task automatic random_manual();
        logic [31:0]    r;
        reg_addr_t      addr;
        for (int i = 0; i < 20; i++)
        begin
            r    = lcg_next();
            addr = reg_addr_t'((r >> 16) % num_regs);
            run_manual("random_manual", addr, r[31]);
        end
    endtask

    initial
    begin
        resetn      = 1'b0;
        auto_scan   = 1'b0;
        upper_half  = 1'b0;
        sel_addr    = '0;
        div         = 26'd3;
        checks      = 0;
        errors      = 0;
        lcg_state   = 32'hf0d44bfb;
        for (int i = 0; i < 32; i++)
            reg_table[i] = lcg_next();

        reset_state();
        manual_lower();
        manual_upper();
        auto_scan_wrap();
        random_manual();

        $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_count);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule : debug_scan_tb

`default_nettype wire

// File: debug_scan_top.f
source/debug_scan_pkg.sv
source/capture_if.sv
source/scan_addr_gen.sv
source/scan_capture.sv
source/seg_display_encode.sv
source/debug_scan_top.sv
bench/debug_scan_tb.sv

// File: Bender.yml
package:
  name: debug_scan

sources:
  # package and interface first, they are used by the stages
  - source/debug_scan_pkg.sv
  - source/capture_if.sv
  - source/scan_addr_gen.sv
  - source/scan_capture.sv
  - source/seg_display_encode.sv
  - source/debug_scan_top.sv
  - target: simulation
    files:
      - bench/debug_scan_tb.sv
